// File: Bender.yml
package:
  name: bridge_top

sources:
  - include_dirs:
      - source
    files:
      - source/busPkg.sv
      - source/timerPkg.sv
      - source/busIf.sv
      - source/northBridge.sv
      - source/dataMemory.sv
      - source/southBridge.sv
      - source/timer.sv
      - source/bridgeTop.sv

  - target: test
    include_dirs:
      - source
    files:
      - tests/bridgeTopTb.sv

// File: build.f
+incdir+source
source/busPkg.sv
source/timerPkg.sv
source/busIf.sv
source/northBridge.sv
source/dataMemory.sv
source/southBridge.sv
source/timer.sv
source/bridgeTop.sv
tests/bridgeTopTb.sv

// File: source/bridgeTop.sv
// Data-side bridge top level
// North bridge, data memory, south bridge and two timers

`timescale 1ns/1ns
`include "bridge_config.svh"

module bridgeTop (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [31:0]                    addr,
    input  logic [31:0]                    wData,
    input  logic [3:0]                     we,
    input  logic                           rd,
    input  logic                           extInt,
    output logic [31:0]                    rData,
    output busPkg::excCodeT                exc,
    output logic [`BRIDGE_HWINT_WIDTH-1:0] hwInt
);

    // CPU side to memory and device bus
    busIf #(.dataWidth(32)) memBus ();
    busIf #(.dataWidth(32)) devBus ();

    // South bridge to each timer
    busIf #(.dataWidth(32)) tmr0Bus ();
    busIf #(.dataWidth(32)) tmr1Bus ();

    logic tmr0Irq;
    logic tmr1Irq;

    northBridge i_northBridge (
        .cpuAddr  (addr),
        .cpuWData (wData),
        .cpuWe    (we),
        .cpuRd    (rd),
        .cpuRData (rData),
        .exc      (exc),
        .mem      (memBus.master),
        .dev      (devBus.master)
    );

    dataMemory i_dataMemory (
        .clk   (clk),
        .reset (reset),
        .bus   (memBus.slave)
    );

    southBridge i_southBridge (
        .host    (devBus.slave),
        .tmr0    (tmr0Bus.master),
        .tmr1    (tmr1Bus.master),
        .tmr0Irq (tmr0Irq),
        .tmr1Irq (tmr1Irq),
        .extInt  (extInt),
        .hwInt   (hwInt)
    );

    timer i_timer0 (
        .clk   (clk),
        .reset (reset),
        .bus   (tmr0Bus.slave),
        .irq   (tmr0Irq)
    );

    timer i_timer1 (
        .clk   (clk),
        .reset (reset),
        .bus   (tmr1Bus.slave),
        .irq   (tmr1Irq)
    );

endmodule

// File: source/bridge_config.svh
// Address map, data memory depth and interrupt vector width
// Shared by the bridges, the memory and the top level

`ifndef BRIDGE_CONFIG_SVH
`define BRIDGE_CONFIG_SVH

// Data memory depth in 32-bit words
`define BRIDGE_DM_WORDS 3072

// Byte address limit of the data memory region
`define BRIDGE_DM_LIMIT (`BRIDGE_DM_WORDS * 4)

// Timer register windows, both 16-byte aligned
`define BRIDGE_TIMER0_BASE 32'h0000_7F00
`define BRIDGE_TIMER1_BASE 32'h0000_7F10

// Registers per timer: ctrl, preset, count
`define BRIDGE_TIMER_WORDS 3

// Hardware interrupt vector width
`define BRIDGE_HWINT_WIDTH 6

`endif

// File: source/busIf.sv
// Word bus interface between bridge stages and devices
// Plain strobes only, no handshake

`timescale 1ns/1ns

interface busIf #(
    parameter int dataWidth = 32
) ();

    logic [dataWidth-1:0]   addr;
    logic [dataWidth-1:0]   wData;
    // One write enable per byte lane
    logic [dataWidth/8-1:0] we;
    logic                   rd;
    logic [dataWidth-1:0]   rData;

    // Requesting side
    modport master (output addr, wData, we, rd, input rData);

    // Responding side
    modport slave (input addr, wData, we, rd, output rData);

endinterface

// File: source/busPkg.sv
// Bus-level types for the data-side bridge
// Access target select and CPU exception codes

package busPkg;

    // Where the north bridge routes a CPU data access
    typedef enum logic [1:0] {
        dataMem = 2'd0,
        device  = 2'd1,
        none    = 2'd2
    } targetT;

    // Exception codes as seen by the CPU cause register
    // Only address errors can come out of the bridge
    typedef enum logic [4:0] {
        // No exception, access proceeds
        excNone = 5'd0,
        // Address error on load
        excAdEL = 5'd4,
        // Address error on store
        excAdES = 5'd5
    } excCodeT;

endpackage

// File: source/dataMemory.sv
// Byte-writable data memory with combinational word read

`timescale 1ns/1ns
`include "bridge_config.svh"

module dataMemory (
    input logic clk,
    input logic reset,
    busIf.slave bus
);

    localparam int depth      = `BRIDGE_DM_WORDS;
    localparam int indexWidth = $clog2(depth);

    logic [31:0]           mem [depth];
    logic [indexWidth-1:0] wordIndex;

    // Byte address to word index
    assign wordIndex = bus.addr[indexWidth+1:2];

    assign bus.rData = mem[wordIndex];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < depth; i++) begin
                mem[i] <= '0;
            end
        end else begin
            // Each enabled lane updates its own byte
            for (int lane = 0; lane < 4; lane++) begin
                if (bus.we[lane]) begin
                    mem[wordIndex][lane*8 +: 8] <= bus.wData[lane*8 +: 8];
                end
            end
        end
    end

    // Decode upstream must keep accesses inside the array
    assert property (@(posedge clk) disable iff (reset)
        (bus.rd || |bus.we) |-> (bus.addr[31:2] < 30'(depth)))
        else $error("dataMemory: word index %0d beyond depth", bus.addr[31:2]);

endmodule

// File: source/northBridge.sv
// CPU-side address decode with exception detection
// Routes data accesses to memory or the device bus and returns read data

`timescale 1ns/1ns
`include "bridge_config.svh"

module northBridge (
    input  logic [31:0]     cpuAddr,
    input  logic [31:0]     cpuWData,
    input  logic [3:0]      cpuWe,
    input  logic            cpuRd,
    output logic [31:0]     cpuRData,
    output busPkg::excCodeT exc,
    busIf.master            mem,
    busIf.master            dev
);

    localparam logic [31:0] dmLimit     = `BRIDGE_DM_LIMIT;
    localparam logic [31:0] timer0Base  = `BRIDGE_TIMER0_BASE;
    localparam logic [31:0] timer1Base  = `BRIDGE_TIMER1_BASE;
    localparam logic [31:0] windowBytes = `BRIDGE_TIMER_WORDS * 4;
    localparam logic [31:0] countOffset = 32'h8;

    busPkg::targetT target;
    logic           inTimer0;
    logic           inTimer1;
    logic           isWrite;
    logic           isCount;
    logic           blocked;
    logic [31:0]    devOffset;

    assign inTimer0 = (cpuAddr >= timer0Base) && (cpuAddr < timer0Base + windowBytes);
    assign inTimer1 = (cpuAddr >= timer1Base) && (cpuAddr < timer1Base + windowBytes);
    assign isWrite  = |cpuWe;

    // Byte offset inside whichever timer window was hit
    assign devOffset = inTimer0 ? (cpuAddr - timer0Base) : (cpuAddr - timer1Base);
    assign isCount   = devOffset[31:2] == countOffset[31:2];

    always_comb begin
        if (cpuAddr < dmLimit) begin
            target = busPkg::dataMem;
        end else if (inTimer0 || inTimer1) begin
            target = busPkg::device;
        end else begin
            target = busPkg::none;
        end
    end

    // Stores take precedence when both strobes hit an unmapped address
    always_comb begin
        exc = busPkg::excNone;
        if (target == busPkg::none) begin
            if (isWrite) begin
                exc = busPkg::excAdES;
            end else if (cpuRd) begin
                exc = busPkg::excAdEL;
            end
        end else if (target == busPkg::device && isWrite) begin
            // Devices take full words only, and count is read-only
            if (cpuWe != 4'hF || isCount) begin
                exc = busPkg::excAdES;
            end
        end
    end

    assign blocked = exc != busPkg::excNone;

    assign mem.addr  = cpuAddr;
    assign mem.wData = cpuWData;
    assign mem.we    = (target == busPkg::dataMem && !blocked) ? cpuWe : 4'h0;
    assign mem.rd    = (target == busPkg::dataMem && !blocked) && cpuRd;

    assign dev.addr  = cpuAddr;
    assign dev.wData = cpuWData;
    assign dev.we    = (target == busPkg::device && !blocked) ? cpuWe : 4'h0;
    assign dev.rd    = (target == busPkg::device && !blocked) && cpuRd;

    always_comb begin
        if (blocked) begin
            cpuRData = '0;
        end else if (target == busPkg::dataMem) begin
            cpuRData = mem.rData;
        end else if (target == busPkg::device) begin
            cpuRData = dev.rData;
        end else begin
            cpuRData = '0;
        end
    end

    // A store lands in exactly one place
    always_comb begin
        assert final (!(|mem.we && |dev.we))
            else $error("northBridge: memory and device written together");
    end

endmodule

// File: source/southBridge.sv
// Device register decode, read-data mux and interrupt vector assembly
// Two timers behind one device bus

`timescale 1ns/1ns
`include "bridge_config.svh"

module southBridge (
    busIf.slave                           host,
    busIf.master                          tmr0,
    busIf.master                          tmr1,
    input  logic                          tmr0Irq,
    input  logic                          tmr1Irq,
    input  logic                          extInt,
    output logic [`BRIDGE_HWINT_WIDTH-1:0] hwInt
);

    localparam logic [31:0] timer0Base = `BRIDGE_TIMER0_BASE;
    localparam logic [31:0] timer1Base = `BRIDGE_TIMER1_BASE;

    logic               sel0;
    logic               sel1;
    logic               writeReq;
    timerPkg::regIndexT regIndex;

    // Windows are 16-byte aligned, so the upper bits pick the timer
    assign sel0 = host.addr[31:4] == timer0Base[31:4];
    assign sel1 = host.addr[31:4] == timer1Base[31:4];

    assign regIndex = timerPkg::regIndexT'(host.addr[3:2]);

    // Device stores are full words
    assign writeReq = host.we[0];

    assign tmr0.addr  = {30'b0, regIndex};
    assign tmr0.wData = host.wData;
    assign tmr0.we    = (sel0 && writeReq) ? 4'hF : 4'h0;
    assign tmr0.rd    = sel0 && host.rd;

    assign tmr1.addr  = {30'b0, regIndex};
    assign tmr1.wData = host.wData;
    assign tmr1.we    = (sel1 && writeReq) ? 4'hF : 4'h0;
    assign tmr1.rd    = sel1 && host.rd;

    always_comb begin
        if (sel0) begin
            host.rData = tmr0.rData;
        end else if (sel1) begin
            host.rData = tmr1.rData;
        end else begin
            host.rData = '0;
        end
    end

    // Bit 0 timer 0, bit 1 timer 1, bit 2 external line, rest unused
    assign hwInt = {{(`BRIDGE_HWINT_WIDTH-3){1'b0}}, extInt, tmr1Irq, tmr0Irq};

    // Overlapping timer windows would break the read mux
    always_comb begin
        assert final ($onehot0({sel0, sel1}))
            else $error("southBridge: both timers selected at %h", host.addr);
    end

endmodule

// File: source/timer.sv
// Programmable countdown timer with oneShot and autoReload modes
// Registers ctrl, preset and count, with a registered interrupt

`timescale 1ns/1ns

module timer (
    input  logic clk,
    input  logic reset,
    busIf.slave  bus,
    output logic irq
);

    timerPkg::ctrlWordT ctrlReg;
    logic [31:0]        presetReg;
    logic [31:0]        countReg;
    timerPkg::regIndexT regIndex;
    logic               writeEn;
    logic               presetWrite;
    logic               isAutoReload;
    logic               reloadNow;
    logic               irqNext;

    assign regIndex     = timerPkg::regIndexT'(bus.addr[1:0]);
    assign writeEn      = |bus.we;
    assign presetWrite  = writeEn && regIndex == timerPkg::preset;
    assign isAutoReload = ctrlReg.fields.mode == timerPkg::autoReload;

    // Reload point in autoReload mode
    assign reloadNow = ctrlReg.fields.enable && isAutoReload && countReg == 32'd1;

    always_comb begin
        if (!ctrlReg.fields.intMask || !ctrlReg.fields.enable) begin
            irqNext = 1'b0;
        end else if (isAutoReload) begin
            irqNext = reloadNow;
        end else begin
            // oneShot holds the request while expired
            irqNext = countReg == 32'd0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrlReg   <= '0;
            presetReg <= '0;
            countReg  <= '0;
            irq       <= 1'b0;
        end else begin
            irq <= irqNext;
            if (writeEn && regIndex == timerPkg::ctrl) begin
                ctrlReg.raw <= bus.wData;
            end
            // Preset write also restarts the count
            if (presetWrite) begin
                presetReg <= bus.wData;
                countReg  <= bus.wData;
            end else if (reloadNow) begin
                countReg <= presetReg;
            end else if (ctrlReg.fields.enable && countReg != 32'd0) begin
                countReg <= countReg - 32'd1;
            end
        end
    end

    always_comb begin
        case (regIndex)
            timerPkg::ctrl:   bus.rData = ctrlReg.raw;
            timerPkg::preset: bus.rData = presetReg;
            timerPkg::count:  bus.rData = countReg;
            default:          bus.rData = '0;
        endcase
    end

    // Count only moves up on a preset load or a reload
    assert property (@(posedge clk) disable iff (reset)
        (!presetWrite && !reloadNow) |=> (countReg <= $past(countReg)))
        else $error("timer: count rose from %0d to %0d", $past(countReg), countReg);

endmodule

// File: source/timerPkg.sv
// Timer register index, mode and control word types
// The control word is both read back raw and decoded into fields

package timerPkg;

    // Word register index inside a timer window
    typedef enum logic [1:0] {
        ctrl   = 2'd0,
        preset = 2'd1,
        count  = 2'd2
    } regIndexT;

    // Counting mode
    // Codes 2 and 3 behave as oneShot
    typedef enum logic [1:0] {
        oneShot    = 2'd0,
        autoReload = 2'd1
    } modeT;

    // Decoded view of the control word
    typedef struct packed {
        logic [27:0] reserved;
        logic        intMask;
        modeT        mode;
        logic        enable;
    } ctrlFieldsT;

    typedef union packed {
        logic [31:0] raw;
        ctrlFieldsT  fields;
    } ctrlWordT;

endpackage

// File: tests/bridgeTopTb.sv
// Testbench for the data-side bridge top level
// Shadow memory and timer models, checked by concurrent assertions

`timescale 1ns/1ns
`include "bridge_config.svh"

module bridgeTopTb;

    localparam logic [31:0] dmLimit     = `BRIDGE_DM_LIMIT;
    localparam logic [31:0] timer0Base  = `BRIDGE_TIMER0_BASE;
    localparam logic [31:0] timer1Base  = `BRIDGE_TIMER1_BASE;
    localparam logic [31:0] windowBytes = `BRIDGE_TIMER_WORDS * 4;
    localparam int          numMemOps   = 300;
    localparam int          oneShotLen  = 8;
    localparam int          reloadLen   = 5;
    // Full sequence is close to 1000 cycles, mostly the memory test
    localparam int          maxCycles   = 2000;

    logic                           clk;
    logic                           reset;
    logic [31:0]                    addr;
    logic [31:0]                    wData;
    logic [3:0]                     we;
    logic                           rd;
    logic                           extInt;
    logic [31:0]                    rData;
    busPkg::excCodeT                exc;
    logic [`BRIDGE_HWINT_WIDTH-1:0] hwInt;

    integer seed = 31;
    int     cycleCount = 0;
    string  testName = "reset";
    // Name of the access being checked, one cycle behind the stimulus
    string  checkName = "reset";

    // Reference model state
    logic [31:0]        shadowMem [`BRIDGE_DM_WORDS];
    timerPkg::ctrlWordT modelCtrl [2];
    logic [31:0]        modelPreset [2];
    logic [31:0]        modelCount [2];
    logic               modelIrq [2];

    logic                           inMem;
    logic                           inT0;
    logic                           inT1;
    logic                           isDev;
    logic                           memWrite;
    logic                           devWrite;
    logic [1:0]                     regOff;
    logic [31:0]                    expRData;
    busPkg::excCodeT                expExc;
    logic [`BRIDGE_HWINT_WIDTH-1:0] expHwInt;

    bridgeTop i_bridgeTop (
        .clk    (clk),
        .reset  (reset),
        .addr   (addr),
        .wData  (wData),
        .we     (we),
        .rd     (rd),
        .extInt (extInt),
        .rData  (rData),
        .exc    (exc),
        .hwInt  (hwInt)
    );

    always #4 clk = ~clk;

    assign inMem  = addr < dmLimit;
    assign inT0   = (addr >= timer0Base) && (addr < timer0Base + windowBytes);
    assign inT1   = (addr >= timer1Base) && (addr < timer1Base + windowBytes);
    assign isDev  = inT0 || inT1;
    // Both windows are 16-byte aligned
    assign regOff = addr[3:2];

    assign memWrite = inMem && |we;
    // Full-word stores only, and count is read-only
    assign devWrite = isDev && we == 4'hF && regOff != 2'd2;

    always_comb begin
        expExc   = busPkg::excNone;
        expRData = '0;
        if (inMem) begin
            expRData = shadowMem[addr[31:2]];
        end else if (isDev) begin
            if (|we && !devWrite) begin
                expExc = busPkg::excAdES;
            end else if (regOff == 2'd0) begin
                expRData = modelCtrl[inT1].raw;
            end else if (regOff == 2'd1) begin
                expRData = modelPreset[inT1];
            end else begin
                expRData = modelCount[inT1];
            end
        end else if (|we) begin
            expExc = busPkg::excAdES;
        end else if (rd) begin
            expExc = busPkg::excAdEL;
        end
    end

    assign expHwInt = {{(`BRIDGE_HWINT_WIDTH-3){1'b0}}, extInt, modelIrq[1], modelIrq[0]};

    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `BRIDGE_DM_WORDS; i++) begin
                shadowMem[i] <= '0;
            end
            for (int t = 0; t < 2; t++) begin
                modelCtrl[t]   <= '0;
                modelPreset[t] <= '0;
                modelCount[t]  <= '0;
                modelIrq[t]    <= 1'b0;
            end
        end else begin
            for (int lane = 0; lane < 4; lane++) begin
                if (memWrite && we[lane]) begin
                    shadowMem[addr[31:2]][lane*8 +: 8] <= wData[lane*8 +: 8];
                end
            end
            for (int t = 0; t < 2; t++) begin
                logic hit;
                logic isAuto;
                logic atReload;
                hit      = devWrite && ((t == 1) ? inT1 : inT0);
                isAuto   = modelCtrl[t].fields.mode == timerPkg::autoReload;
                atReload = modelCtrl[t].fields.enable && isAuto && modelCount[t] == 32'd1;
                modelIrq[t] <= modelCtrl[t].fields.intMask && modelCtrl[t].fields.enable
                    && (isAuto ? modelCount[t] == 32'd1 : modelCount[t] == 32'd0);
                if (hit && regOff == 2'd0) begin
                    modelCtrl[t].raw <= wData;
                end
                if (hit && regOff == 2'd1) begin
                    modelPreset[t] <= wData;
                    modelCount[t]  <= wData;
                end else if (atReload) begin
                    modelCount[t] <= modelPreset[t];
                end else if (modelCtrl[t].fields.enable && modelCount[t] != 32'd0) begin
                    modelCount[t] <= modelCount[t] - 32'd1;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        checkName  <= testName;
        if (cycleCount >= maxCycles) begin
            stopWithFailure($sformatf("Timeout: sequence not done after %0d cycles", maxCycles));
        end
    end

    excMatch: assert property (@(posedge clk) disable iff (reset) exc == expExc)
        else reportMismatch("exc", 32'($sampled(expExc)), 32'($sampled(exc)));

    readMatch: assert property (@(posedge clk) disable iff (reset) rd |-> rData == expRData)
        else reportMismatch("rData", $sampled(expRData), $sampled(rData));

    blockedZero: assert property (@(posedge clk) disable iff (reset)
        (exc != busPkg::excNone) |-> rData == 32'h0)
        else reportMismatch("rData on exception", 32'h0, $sampled(rData));

    hwIntMatch: assert property (@(posedge clk) disable iff (reset) hwInt == expHwInt)
        else reportMismatch("hwInt", 32'($sampled(expHwInt)), 32'($sampled(hwInt)));

    task automatic stopWithFailure(input string line);
        $display("%s", line);
        $display(">>> FAIL");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic reportMismatch(input string what, input logic [31:0] expected,
                                  input logic [31:0] actual);
        stopWithFailure($sformatf("FAIL %s %s: expected %h, actual %h",
                                  checkName, what, expected, actual));
    endtask

    // Drives one access at the current edge, returns at the next one
    task automatic driveAccess(input logic [31:0] a, input logic [31:0] d,
                               input logic [3:0] e, input logic r);
        addr  <= a;
        wData <= d;
        we    <= e;
        rd    <= r;
        @(posedge clk);
    endtask

    function automatic logic [31:0] timerAddr(input int t, input int r);
        return ((t == 1) ? timer1Base : timer0Base) + 32'(r * 4);
    endfunction

    task automatic checkResetState();
        testName <= "reset state";
        for (int t = 0; t < 2; t++) begin
            for (int r = 0; r < 3; r++) begin
                driveAccess(timerAddr(t, r), 32'h0, 4'h0, 1'b1);
            end
        end
    endtask

    task automatic memoryLanes();
        logic [31:0] addrQ [$];
        logic [31:0] a;
        logic [3:0]  mask;
        int          kind;
        testName <= "memory lanes";
        // Both ends of the region first
        driveAccess(32'h0, 32'hA5A5_0001, 4'hF, 1'b0);
        driveAccess(32'h0, 32'h0, 4'h0, 1'b1);
        driveAccess(dmLimit - 4, 32'h5A5A_0002, 4'hF, 1'b0);
        driveAccess(dmLimit - 4, 32'h0, 4'h0, 1'b1);
        repeat (numMemOps) begin
            a    = 32'($unsigned($random(seed)) % `BRIDGE_DM_WORDS) * 4;
            kind = $unsigned($random(seed)) % 3;
            if (kind == 0) begin
                mask = 4'hF;
            end else if (kind == 1) begin
                mask = $random(seed) & 1 ? 4'b1100 : 4'b0011;
            end else begin
                mask = 4'b0001 << ($unsigned($random(seed)) % 4);
            end
            driveAccess(a, $random(seed), mask, 1'b0);
            driveAccess(a, 32'h0, 4'h0, 1'b1);
            addrQ.push_back(a);
        end
        foreach (addrQ[i]) begin
            driveAccess(addrQ[i], 32'h0, 4'h0, 1'b1);
        end
    endtask

    task automatic addressExceptions();
        testName <= "address exceptions";
        driveAccess(32'h0000_8000, 32'h0, 4'h0, 1'b1);
        driveAccess(32'hFFFF_FFFC, 32'h0, 4'h0, 1'b1);
        driveAccess(dmLimit, 32'hDEAD_BEEF, 4'hF, 1'b0);
        driveAccess(dmLimit - 4, 32'h0, 4'h0, 1'b1);
        // Gap just past the timer 0 window
        driveAccess(timer0Base + windowBytes, 32'h1111_2222, 4'hF, 1'b0);
        driveAccess(timer0Base + windowBytes, 32'h0, 4'h0, 1'b1);
        // Nonzero registers so a leaked read value would show
        driveAccess(timerAddr(0, 1), 32'h0000_00A5, 4'hF, 1'b0);
        driveAccess(timerAddr(1, 1), 32'h0000_005A, 4'hF, 1'b0);
        driveAccess(timerAddr(0, 1), 32'h0000_1234, 4'b0011, 1'b0);
        driveAccess(timerAddr(0, 0), 32'h0000_0009, 4'b1000, 1'b0);
        driveAccess(timerAddr(1, 2), 32'h0000_0055, 4'hF, 1'b0);
        for (int r = 0; r < 3; r++) begin
            driveAccess(timerAddr(0, r), 32'h0, 4'h0, 1'b1);
            driveAccess(timerAddr(1, r), 32'h0, 4'h0, 1'b1);
        end
    endtask

    task automatic oneShotRun(input logic [31:0] ctrlWord, input string name);
        testName <= name;
        driveAccess(timerAddr(0, 1), oneShotLen, 4'hF, 1'b0);
        driveAccess(timerAddr(0, 0), ctrlWord, 4'hF, 1'b0);
        repeat (oneShotLen + 6) begin
            driveAccess(timerAddr(0, 2), 32'h0, 4'h0, 1'b1);
        end
        driveAccess(timerAddr(0, 0), 32'h0, 4'hF, 1'b0);
        driveAccess(timerAddr(0, 2), 32'h0, 4'h0, 1'b1);
    endtask

    task automatic autoReloadRun();
        testName <= "timer autoReload";
        driveAccess(timerAddr(1, 1), reloadLen, 4'hF, 1'b0);
        // Mask, autoReload mode and enable
        driveAccess(timerAddr(1, 0), 32'h0000_000B, 4'hF, 1'b0);
        repeat (4 * reloadLen + 2) begin
            driveAccess(timerAddr(1, 2), 32'h0, 4'h0, 1'b1);
        end
        driveAccess(timerAddr(1, 1), 32'h0, 4'h0, 1'b1);
        driveAccess(timerAddr(1, 0), 32'h0, 4'hF, 1'b0);
    endtask

    task automatic externalInterrupt();
        testName <= "external interrupt";
        repeat (8) begin
            extInt <= $random(seed) & 1;
            driveAccess(timerAddr(1, 0), 32'h0, 4'h0, 1'b1);
        end
        extInt <= 1'b0;
    endtask

    initial begin
        clk    = 1'b0;
        reset  = 1'b1;
        addr   = '0;
        wData  = '0;
        we     = '0;
        rd     = 1'b0;
        extInt = 1'b0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        checkResetState();
        memoryLanes();
        addressExceptions();
        oneShotRun(32'h0000_0009, "timer oneShot");
        oneShotRun(32'h0000_0001, "timer oneShot masked");
        autoReloadRun();
        externalInterrupt();
        driveAccess(32'h0, 32'h0, 4'h0, 1'b0);
        @(posedge clk);
        $display(">>> PASS");
        $finish;
    end

endmodule
